// ==== soc_periph_top.f ====
+incdir+hw
hw/soc_bus_pkg.sv
hw/ps2_receiver.sv
hw/event_fifo.sv
hw/bus_controller.sv
hw/soc_periph_top.sv
test/tb_clock.sv
test/soc_periph_top_sva.sv
test/soc_periph_top_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_bus_pkg.sv
      - hw/ps2_receiver.sv
      - hw/event_fifo.sv
      - hw/bus_controller.sv
      - hw/soc_periph_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/soc_periph_top_sva.sv
      - test/soc_periph_top_tb.sv

// ==== test/soc_periph_top_tb.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_periph_top_tb;
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_FRAME, OP_ACK} op_kind_t;

    // one table row
    // frames use data[7:0] as the byte and exp_val as the vector afterwards
    typedef struct packed {
        op_kind_t    kind;
        logic [2:0]  test_id;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic        corrupt;
    } op_t;

    localparam int wait_limit = 50;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    bus_req_t    req;
    logic [31:0] rdata;
    logic        rd_valid;
    console_t    con;
    logic [3:0]  irq_vector;
    logic        irq_ack;

    op_t         ops[$];
    logic [31:0] rng;
    int          checks;
    int          errors;

    tb_clock i_tb_clock (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_periph_top i_soc_periph_top (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .PS2_CLK    (PS2_CLK),
        .PS2_DAT    (PS2_DAT),
        .req        (req),
        .rdata      (rdata),
        .rd_valid   (rd_valid),
        .con        (con),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // key register layout with valid at 31, ext 9, brk 8 and code 7:0
    function automatic logic [31:0] key_word(input logic [7:0] code, input logic brk,
                                             input logic ext);
        return {1'b1, 21'd0, ext, brk, code};
    endfunction

    task automatic add_op(input op_kind_t kind, input int id, input logic [15:0] addr,
                          input logic [31:0] data, input logic [31:0] exp_val,
                          input logic corrupt);
        ops.push_back('{kind, id[2:0], addr, data, exp_val, corrupt});
    endtask

    // n edges then 2 ns past the last one
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #2;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        int n;
        req.addr  = addr;
        req.wdata = data;
        req.we    = 1'b1;
        wait_cycles(1);
        req.we = 1'b0;
        if (addr == `CON_ADDR) begin
            n = 0;
            while (!con.valid && n < wait_limit) begin
                wait_cycles(1);
                n++;
            end
            checks++;
            if (!con.valid) begin
                errors++;
                $display("Timeout at %0t: no console strobe after the write", $time);
            end else if (con.data !== data[7:0]) begin
                errors++;
                $display("Fail at %0t: con.data expected %h got %h", $time, data[7:0],
                         con.data);
            end
            // strobe lasts a single cycle
            wait_cycles(1);
            checks++;
            if (con.valid !== 1'b0) begin
                errors++;
                $display("Fail at %0t: con.valid expected 0 got %b", $time, con.valid);
            end
        end
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [31:0] exp_val);
        int n;
        req.addr = addr;
        req.re   = 1'b1;
        wait_cycles(1);
        req.re = 1'b0;
        n = 0;
        while (!rd_valid && n < wait_limit) begin
            wait_cycles(1);
            n++;
        end
        checks++;
        if (!rd_valid) begin
            errors++;
            $display("Timeout at %0t: no rd_valid for read of %h", $time, addr);
        end else if (rdata !== exp_val) begin
            errors++;
            $display("Fail at %0t: rdata expected %h got %h (addr %h)", $time, exp_val,
                     rdata, addr);
        end
    endtask

    // start, eight data bits lsb first, odd parity and stop
    task automatic send_frame(input logic [7:0] code, input logic corrupt);
        logic [10:0] bits;
        int          b;
        bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};
        for (b = 0; b < 11; b++) begin
            PS2_DAT = bits[b];
            wait_cycles(10);
            PS2_CLK = 1'b0;
            wait_cycles(10);
            PS2_CLK = 1'b1;
        end
        // line idle before the next frame
        PS2_DAT = 1'b1;
        wait_cycles(20);
    endtask

    task automatic check_irq(input logic [3:0] exp_val);
        int n;
        n = 0;
        while (irq_vector !== exp_val && n < wait_limit) begin
            wait_cycles(1);
            n++;
        end
        checks++;
        if (irq_vector !== exp_val) begin
            errors++;
            $display("Fail at %0t: irq_vector expected %h got %h", $time, exp_val, irq_vector);
        end
    endtask

    task automatic ack_irq(input logic [3:0] exp_val);
        irq_ack = 1'b1;
        wait_cycles(1);
        irq_ack = 1'b0;
        // cleared by the edge that took the ack
        checks++;
        if (irq_vector !== exp_val) begin
            errors++;
            $display("Fail at %0t: irq_vector expected %h got %h", $time, exp_val, irq_vector);
        end
    endtask

    task automatic build_table();
        logic [15:0] ram_addr[4];
        logic [31:0] words[4];
        int          k;
        ram_addr = '{16'h1000, 16'h1004, 16'h1800, 16'h1FFC};
        for (k = 0; k < 4; k++) begin
            rng      = xorshift32(rng);
            words[k] = rng;
            add_op(OP_WRITE, 1, ram_addr[k], words[k], '0, 1'b0);
        end
        for (k = 0; k < 4; k++) begin
            add_op(OP_READ, 1, ram_addr[k], '0, words[k], 1'b0);
        end
        // below, above and between the windows
        add_op(OP_READ, 1, 16'h0000, '0, `BAD_READ, 1'b0);
        add_op(OP_READ, 1, 16'h2000, '0, `BAD_READ, 1'b0);
        add_op(OP_READ, 1, 16'hFFF0, '0, `BAD_READ, 1'b0);
        // single press
        add_op(OP_FRAME, 2, '0, 32'h1C, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_READ, 2, `KEY_ADDR, '0, key_word(8'h1C, 1'b0, 1'b0), 1'b0);
        add_op(OP_ACK, 2, '0, '0, '0, 1'b0);
        add_op(OP_READ, 2, `KEY_ADDR, '0, '0, 1'b0);
        // extended release raises no interrupt at any step
        add_op(OP_FRAME, 3, '0, 32'hE0, '0, 1'b0);
        add_op(OP_FRAME, 3, '0, 32'hF0, '0, 1'b0);
        add_op(OP_FRAME, 3, '0, 32'h75, '0, 1'b0);
        add_op(OP_READ, 3, `KEY_ADDR, '0, key_word(8'h75, 1'b1, 1'b1), 1'b0);
        add_op(OP_READ, 3, `KEY_ADDR, '0, '0, 1'b0);
        // console byte
        add_op(OP_WRITE, 4, `CON_ADDR, 32'h1234_5641, '0, 1'b0);
        // bad parity is dropped
        add_op(OP_FRAME, 5, '0, 32'h1C, '0, 1'b1);
        add_op(OP_READ, 5, `STAT_ADDR, '0, '0, 1'b0);
        // six presses into four slots
        add_op(OP_FRAME, 6, '0, 32'h15, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_FRAME, 6, '0, 32'h16, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_FRAME, 6, '0, 32'h1E, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_FRAME, 6, '0, 32'h26, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_FRAME, 6, '0, 32'h25, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_FRAME, 6, '0, 32'h2E, 32'(`KEY_IRQ), 1'b0);
        add_op(OP_READ, 6, `STAT_ADDR, '0, 32'h3, 1'b0);
        add_op(OP_READ, 6, `STAT_ADDR, '0, 32'h1, 1'b0);
        add_op(OP_READ, 6, `KEY_ADDR, '0, key_word(8'h15, 1'b0, 1'b0), 1'b0);
        add_op(OP_READ, 6, `KEY_ADDR, '0, key_word(8'h16, 1'b0, 1'b0), 1'b0);
        add_op(OP_READ, 6, `KEY_ADDR, '0, key_word(8'h1E, 1'b0, 1'b0), 1'b0);
        add_op(OP_READ, 6, `KEY_ADDR, '0, key_word(8'h26, 1'b0, 1'b0), 1'b0);
        add_op(OP_READ, 6, `KEY_ADDR, '0, '0, 1'b0);
        add_op(OP_READ, 6, `STAT_ADDR, '0, '0, 1'b0);
        add_op(OP_ACK, 6, '0, '0, '0, 1'b0);
    endtask

    initial begin
        int  i;
        int  n;
        int  group_errs;
        op_t op;
        PS2_CLK    = 1'b1;
        PS2_DAT    = 1'b1;
        req        = '0;
        irq_ack    = 1'b0;
        checks     = 0;
        errors     = 0;
        group_errs = 0;
        rng        = 32'hc62d_0efa;
        build_table();
        n = 0;
        while (KEY0 !== 1'b1 && n < 100) begin
            @(posedge CLOCK_50);
            n++;
        end
        if (KEY0 !== 1'b1) begin
            errors++;
            $display("Timeout at %0t: reset never released", $time);
        end
        wait_cycles(2);
        for (i = 0; i < ops.size(); i++) begin
            op = ops[i];
            case (op.kind)
                OP_WRITE: bus_write(op.addr, op.data);
                OP_READ:  bus_read(op.addr, op.exp_val);
                OP_FRAME: begin
                    send_frame(op.data[7:0], op.corrupt);
                    check_irq(op.exp_val[3:0]);
                end
                default:  ack_irq(op.exp_val[3:0]);
            endcase
            // last row of a test closes it
            if (i == ops.size() - 1 || ops[i + 1].test_id != op.test_id) begin
                $display("test %0d finished, %0d failures", op.test_id, errors - group_errs);
                group_errs = errors;
            end
        end
        // bound assertions that fired during the run
        if (i_soc_periph_top.i_soc_periph_top_sva.fail_count != 0) begin
            errors += i_soc_periph_top.i_soc_periph_top_sva.fail_count;
            $display("%0d concurrent assertions failed during the run",
                     i_soc_periph_top.i_soc_periph_top_sva.fail_count);
        end
        $display("checks %0d, failures %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== test/soc_periph_top_sva.sv ====
`timescale 1ns/1ps

module soc_periph_top_sva (
    input logic                  CLOCK_50,
    input logic                  KEY0,
    input soc_bus_pkg::bus_req_t req,
    input logic                  rd_valid,
    input logic [3:0]            irq_vector,
    input logic                  irq_ack
);
    // failed assertions so far, summed into the run result
    int fail_count = 0;

    // master never reads and writes at once
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(req.we && req.re))
        else begin
            $error("write and read strobes high in the same cycle");
            fail_count++;
        end

    // every read answered on the next edge
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.re |=> rd_valid)
        else begin
            $error("read strobe not followed by rd_valid");
            fail_count++;
        end

    // and no answer without a read before it
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rd_valid |-> $past(req.re))
        else begin
            $error("rd_valid without a read one cycle before");
            fail_count++;
        end

    // vector drops only on an acknowledge
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ($past(irq_vector) != 4'd0 && irq_vector == 4'd0) |-> $past(irq_ack))
        else begin
            $error("irq_vector cleared without irq_ack");
            fail_count++;
        end

endmodule

bind soc_periph_top soc_periph_top_sva i_soc_periph_top_sva (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .req        (req),
    .rd_valid   (rd_valid),
    .irq_vector (irq_vector),
    .irq_ack    (irq_ack)
);

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);
    // 50 MHz, 20 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #10 CLOCK_50 = ~CLOCK_50;
        end
    end

    // reset low for ten rising edges, released off the edge
    initial begin
        KEY0 = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
    end

endmodule

// ==== hw/soc_periph_top.sv ====
`timescale 1ns/1ps

module soc_periph_top (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  PS2_CLK,
    input  logic                  PS2_DAT,
    input  soc_bus_pkg::bus_req_t req,
    output logic [31:0]           rdata,
    output logic                  rd_valid,
    output soc_bus_pkg::console_t con,
    output logic [3:0]            irq_vector,
    input  logic                  irq_ack
);
    import soc_bus_pkg::*;

    // receiver to fifo
    key_event_t ev;
    logic       ev_strobe;

    // fifo to controller
    key_event_t head;
    logic       nonempty;
    logic       overflow;
    logic       pop;
    logic       ovf_clear;

    ps2_receiver i_ps2_receiver (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (PS2_CLK),
        .ps2_dat   (PS2_DAT),
        .ev        (ev),
        .ev_strobe (ev_strobe)
    );

    event_fifo #(
        .payload_t (key_event_t)
    ) i_event_fifo (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .push      (ev_strobe),
        .din       (ev),
        .pop       (pop),
        .head      (head),
        .nonempty  (nonempty),
        .overflow  (overflow),
        .ovf_clear (ovf_clear)
    );

    // interrupt taken straight from the receiver strobe
    bus_controller i_bus_controller (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .rdata      (rdata),
        .rd_valid   (rd_valid),
        .head       (head),
        .nonempty   (nonempty),
        .overflow   (overflow),
        .ev_pushed  (ev_strobe),
        .ev_brk     (ev.brk),
        .pop        (pop),
        .ovf_clear  (ovf_clear),
        .con        (con),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

endmodule

// ==== hw/bus_controller.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_controller (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  soc_bus_pkg::bus_req_t   req,
    output logic [31:0]             rdata,
    output logic                    rd_valid,
    input  soc_bus_pkg::key_event_t head,
    input  logic                    nonempty,
    input  logic                    overflow,
    input  logic                    ev_pushed,
    input  logic                    ev_brk,
    output logic                    pop,
    output logic                    ovf_clear,
    output soc_bus_pkg::console_t   con,
    output logic [3:0]              irq_vector,
    input  logic                    irq_ack
);
    import soc_bus_pkg::*;

    localparam int ram_words = `RAM_SIZE / 4;
    localparam int ram_aw    = $clog2(ram_words);

    // word-wide ram, whole-word writes only
    logic [31:0]       ram [ram_words];
    logic [15:0]       ram_off;
    logic [ram_aw-1:0] ram_idx;

    // address decode
    logic ram_sel;
    logic stat_sel;
    logic key_sel;
    logic con_sel;

    // read value for everything but ram
    logic [31:0] reg_rd;
    // registered read side
    logic [31:0] ram_q;
    logic [31:0] reg_q;
    logic        rd_ram_q;

    // console byte held for one cycle
    logic        con_valid_q;
    logic [7:0]  con_data_q;

    assign ram_sel  = (req.addr >= `RAM_BASE) && (req.addr < `RAM_BASE + `RAM_SIZE);
    assign stat_sel = (req.addr == `STAT_ADDR);
    assign key_sel  = (req.addr == `KEY_ADDR);
    assign con_sel  = (req.addr == `CON_ADDR);

    // byte offset into the window, then word index
    assign ram_off = req.addr - `RAM_BASE;
    assign ram_idx = ram_off[ram_aw+1:2];

    // key reg: valid at bit 31, ext 9, brk 8, code 7:0
    always_comb begin
        if (key_sel) begin
            if (nonempty) begin
                reg_rd = {1'b1, 21'd0, head.ext, head.brk, head.code};
            end else begin
                reg_rd = '0;
            end
        end else if (stat_sel) begin
            reg_rd = {30'd0, overflow, nonempty};
        end else begin
            reg_rd = `BAD_READ;
        end
    end

    // key read consumes the head in the same edge it is sampled
    assign pop       = req.re && key_sel && nonempty;
    // status read clears the sticky flag
    assign ovf_clear = req.re && stat_sel;

    always_ff @(posedge CLOCK_50) begin
        if (req.we && ram_sel) begin
            ram[ram_idx] <= req.wdata;
        end
        if (req.re) begin
            ram_q <= ram[ram_idx];
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (req.re) begin
            reg_q <= reg_rd;
        end
        if (req.we && con_sel) begin
            con_data_q <= req.wdata[7:0];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_valid    <= 1'b0;
            rd_ram_q    <= 1'b0;
            con_valid_q <= 1'b0;
            irq_vector  <= 4'd0;
        end else begin
            // one answer per read, back to back allowed
            rd_valid <= req.re;
            if (req.re) begin
                rd_ram_q <= ram_sel;
            end
            con_valid_q <= req.we && con_sel;
            // a new press wins over an ack in the same cycle
            if (ev_pushed && !ev_brk) begin
                irq_vector <= `KEY_IRQ;
            end else if (irq_ack && (irq_vector != 4'd0)) begin
                irq_vector <= 4'd0;
            end
        end
    end

    // final read mux after the registers
    assign rdata = rd_ram_q ? ram_q : reg_q;

    assign con = console_t'{valid: con_valid_q, data: con_data_q};

endmodule

// ==== hw/event_fifo.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = `FIFO_DEPTH
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t head,
    output logic     nonempty,
    output logic     overflow,
    input  logic     ovf_clear
);
    // pointer width, at least one bit
    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    payload_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [aw:0]   count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    // wrap by hand so any depth works
    function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
        return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == (aw + 1)'(depth));
    assign nonempty = (count != '0);
    // show-ahead, head valid whenever nonempty
    assign head     = mem[rd_ptr];
    // pop on empty is ignored
    assign do_pop   = pop && nonempty;
    // a pop in the same cycle frees the slot
    assign do_push  = push && (!full || do_pop);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a lost push beats the clear
            if (push && !do_push) begin
                overflow <= 1'b1;
            end else if (ovf_clear) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== hw/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    output soc_bus_pkg::key_event_t ev,
    output logic                    ev_strobe
);
    import soc_bus_pkg::*;

    // two-flop synchronizers, both lines idle high
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    // last synchronized clock level
    logic        clk_prev;
    // device shifts data out on the falling edge
    logic        fall;

    // lsb-first shift register for one frame
    logic [10:0] shift;
    logic [3:0]  bit_cnt;
    // frame including the bit sampled now
    logic [10:0] frame;
    logic        frame_done;
    logic        frame_ok;
    logic [7:0]  data_byte;
    logic        is_prefix;
    logic        emit;

    // prefixes held until the next data byte
    logic        brk_pend;
    logic        ext_pend;

    assign fall       = clk_prev && !clk_sync[1];
    assign frame      = {dat_sync[1], shift[10:1]};
    // eleventh bit is the stop bit
    assign frame_done = fall && (bit_cnt == 4'd10);
    // start low, stop high, odd parity over data and parity bit
    assign frame_ok   = !frame[0] && frame[10] && (^frame[9:1]);
    assign data_byte  = frame[8:1];
    assign is_prefix  = (data_byte == 8'hF0) || (data_byte == 8'hE0);
    assign emit       = frame_done && frame_ok && !is_prefix;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync  <= 2'b11;
            dat_sync  <= 2'b11;
            clk_prev  <= 1'b1;
            bit_cnt   <= 4'd0;
            brk_pend  <= 1'b0;
            ext_pend  <= 1'b0;
            ev_strobe <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            dat_sync  <= {dat_sync[0], ps2_dat};
            clk_prev  <= clk_sync[1];
            // strobe lasts one cycle only
            ev_strobe <= emit;
            if (fall) begin
                bit_cnt <= frame_done ? 4'd0 : bit_cnt + 4'd1;
            end
            // bad frames fall through here untouched
            if (frame_done && frame_ok) begin
                if (data_byte == 8'hF0) begin
                    brk_pend <= 1'b1;
                end else if (data_byte == 8'hE0) begin
                    ext_pend <= 1'b1;
                end else begin
                    brk_pend <= 1'b0;
                    ext_pend <= 1'b0;
                end
            end
        end
    end

    // shift register and event payload
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            shift <= frame;
        end
        if (emit) begin
            ev <= key_event_t'{code: data_byte, brk: brk_pend, ext: ext_pend};
        end
    end

endmodule

// ==== hw/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // one decoded keyboard event
    // code sits in the high bits, the flags below it
    typedef struct packed {
        // raw set-2 scan code
        logic [7:0] code;
        // key released, F0 seen before the code
        logic       brk;
        // extended key, E0 seen before the code
        logic       ext;
    } key_event_t;

    // single-cycle request from the bus master
    // no handshake, the slave always takes it
    typedef struct packed {
        // byte address, low two bits ignored for ram
        logic [15:0] addr;
        // write payload, whole word
        logic [31:0] wdata;
        // write strobe
        logic        we;
        // read strobe
        // never high together with we
        logic        re;
    } bus_req_t;

    // console output toward the uart side
    typedef struct packed {
        // one-cycle strobe per byte
        logic       valid;
        // character, low byte of the bus write
        logic [7:0] data;
    } console_t;

    // widths used on the wires
    // key_event_t  10 bits
    // bus_req_t    50 bits
    // console_t     9 bits

endpackage

// ==== hw/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ram window, byte addressed
`define RAM_BASE   16'h1000
// 4 KB of ram, 1024 words
`define RAM_SIZE   4096

// single-word registers at the top of the map
// status, bit 0 nonempty and bit 1 overflow
`define STAT_ADDR  16'hFFF4
// key register, pops on read
`define KEY_ADDR   16'hFFF8
// console, write only
`define CON_ADDR   16'hFFFC

// key event buffer entries
`define FIFO_DEPTH 4

// vector raised on a key press
`define KEY_IRQ    4'd1

// returned for unmapped reads
`define BAD_READ   32'hDEADBEEF

`endif
